//--- Makefile
# Verilator flow for the CNN classifier testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module cnn_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module cnn_tb -Mdir $(OBJ_DIR) -o cnn_sim
	./$(OBJ_DIR)/cnn_sim | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/cnn_ref.svh
`ifndef CNN_REF_SVH
`define CNN_REF_SVH

// Model copies of the image and of every coefficient
int img_m    [IMG_SIZE][IMG_SIZE];
int conv_w_m [NCH*KSIZE*KSIZE];
int conv_b_m [NCH];
int fc_w_m   [NCLASS*NFEAT];
int fc_b_m   [NCLASS];

logic [31:0] rng_state = 32'h2fcd;

function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic int rand_byte();
    return int'(next_rand() % 32'd256) - 128;   // Signed INT8 range
endfunction

// One convolution output after bias, shift and 12 bit clamp
function automatic int conv_at(int ch, int oy, int ox);
    int sum;
    sum = conv_b_m[ch];
    for (int r = 0; r < KSIZE; r++) begin
        for (int c = 0; c < KSIZE; c++) begin
            sum += img_m[oy+r][ox+c] * conv_w_m[ch*KSIZE*KSIZE + r*KSIZE + c];
        end
    end
    sum = sum >>> CONV_SHIFT;
    if (sum > 2047) return 2047;
    if (sum < -2048) return -2048;
    return sum;
endfunction

function automatic int pool_at(int ch, int py, int px);
    int best;
    int v;
    best = conv_at(ch, 2*py, 2*px);
    for (int k = 1; k < 4; k++) begin
        v = conv_at(ch, 2*py + k/2, 2*px + k%2);
        if (v > best) best = v;
    end
    return (best < 0) ? 0 : best;               // ReLU
endfunction

function automatic int predict_class();
    int feat [NFEAT];
    int acc;
    int best_acc;
    int best;
    best_acc = 0;
    best     = 0;
    for (int py = 0; py < POOL_SIZE; py++) begin
        for (int px = 0; px < POOL_SIZE; px++) begin
            for (int ch = 0; ch < NCH; ch++) begin
                feat[(py*POOL_SIZE + px)*NCH + ch] = pool_at(ch, py, px);
            end
        end
    end
    for (int n = 0; n < NCLASS; n++) begin
        acc = fc_b_m[n];
        for (int f = 0; f < NFEAT; f++) acc += feat[f] * fc_w_m[n*NFEAT + f];
        if (n == 0 || acc > best_acc) begin     // Strict compare keeps lowest index
            best_acc = acc;
            best     = n;
        end
    end
    return best;
endfunction

`endif

//--- bench/cnn_tb.sv
`timescale 1ns/10ps

module cnn_tb;
    import cnn_pkg::*;

    localparam int IMG_SIZE  = 12;
    localparam int POOL_SIZE = (IMG_SIZE - (KSIZE - 1)) / 2;
    localparam int NFEAT     = NCH * POOL_SIZE * POOL_SIZE;
    localparam int TIMEOUT   = 500;             // Cycles from last pixel to done

    logic        clk_i;
    logic        rstn_i;
    pix_strobe_t pix_i;
    coef_wr_t    coef_i;
    logic [3:0]  result_o;
    logic        done_o;

    int    errors;
    int    timeouts;
    int    done_seen;
    int    last_result;
    int    exp_q [$];                           // Predicted classes in flight
    string msg_q [$];

    `include "cnn_ref.svh"

    cnn_top #(.IMG_SIZE(IMG_SIZE)) cnn_top_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .pix_i    (pix_i),
        .coef_i   (coef_i),
        .result_o (result_o),
        .done_o   (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////
    // Checking and closing

    task automatic check_equal(int got, int exp, string msg);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    always @(posedge clk_i) begin
        if (rstn_i && done_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: done_o pulsed with no image outstanding", $time);
            end else begin
                check_equal(int'(result_o), exp_q.pop_front(), msg_q.pop_front());
            end
            last_result <= int'(result_o);
            done_seen   <= done_seen + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic apply_reset();
        @(posedge clk_i);
        rstn_i <= 1'b0;
        pix_i  <= '0;
        coef_i <= '0;
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
    endtask

    task automatic write_coef(coef_kind_e kind, int addr, int data);
        @(posedge clk_i);
        coef_i <= '{valid: 1'b1, kind: kind, addr: 10'(addr), data: coef_t'(data)};
    endtask

    task automatic idle_coef();
        @(posedge clk_i);
        coef_i <= '0;
    endtask

    task automatic load_conv();
        for (int i = 0; i < NCH*KSIZE*KSIZE; i++) write_coef(CONV_W, i, conv_w_m[i]);
        for (int i = 0; i < NCH; i++) write_coef(CONV_B, i, conv_b_m[i]);
        idle_coef();
    endtask

    task automatic load_fc_w();
        for (int i = 0; i < NCLASS*NFEAT; i++) write_coef(FC_W, i, fc_w_m[i]);
        idle_coef();
    endtask

    task automatic load_fc_b();
        for (int i = 0; i < NCLASS; i++) write_coef(FC_B, i, fc_b_m[i]);
        idle_coef();
    endtask

    task automatic new_coefs();
        for (int i = 0; i < NCH*KSIZE*KSIZE; i++) conv_w_m[i] = rand_byte();
        for (int i = 0; i < NCH; i++) conv_b_m[i] = rand_byte();
        for (int i = 0; i < NCLASS*NFEAT; i++) fc_w_m[i] = rand_byte();
        for (int i = 0; i < NCLASS; i++) fc_b_m[i] = rand_byte();
    endtask

    task automatic new_image();
        for (int y = 0; y < IMG_SIZE; y++) begin
            for (int x = 0; x < IMG_SIZE; x++) img_m[y][x] = rand_byte();
        end
    endtask

    // Row-major pixels with max_gap 0 meaning back to back
    task automatic send_image(int max_gap);
        int gap;
        for (int y = 0; y < IMG_SIZE; y++) begin
            for (int x = 0; x < IMG_SIZE; x++) begin
                @(posedge clk_i);
                pix_i <= '{valid: 1'b1, data: pix_t'(img_m[y][x])};
                gap = (max_gap == 0) ? 0 : 1 + int'(next_rand() % 32'(max_gap));
                repeat (gap) begin
                    @(posedge clk_i);
                    pix_i <= '0;
                end
            end
        end
        @(posedge clk_i);
        pix_i <= '0;
    endtask

    task automatic wait_done(int target);
        int cycles;
        cycles = 0;
        while (done_seen < target && cycles <= TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (done_seen < target) begin
            timeouts++;
            $display("Error at %0t: no done_o within %0d cycles of the last pixel",
                     $time, TIMEOUT);
            finish_run();
        end
    endtask

    task automatic run_frame(int max_gap, string msg);
        int target;
        target = done_seen + 1;
        exp_q.push_back(predict_class());
        msg_q.push_back(msg);
        send_image(max_gap);
        wait_done(target);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Scenarios

    initial begin
        int old_class;
        int plain_class;
        rstn_i = 1'b0;
        pix_i  = '0;
        coef_i = '0;
        apply_reset();

        new_coefs();
        load_conv();
        load_fc_w();
        load_fc_b();
        new_image();
        run_frame(0, "random frame");
        for (int i = 0; i < 3; i++) begin
            new_image();
            run_frame(0, "persistent coefficients");
        end

        // Next class gets all large weights on the same image
        old_class = last_result;
        for (int i = 0; i < NCLASS*NFEAT; i++) begin
            fc_w_m[i] = (i / NFEAT == (old_class + 1) % NCLASS) ? 127 : rand_byte();
        end
        load_fc_w();
        run_frame(0, "reloaded classifier weights");
        check_equal(int'(last_result != old_class), 1, "class change after reload");

        new_image();
        run_frame(0, "gapless stream");
        plain_class = last_result;
        run_frame(5, "stream with gaps");
        check_equal(last_result, plain_class, "gapped against gapless");

        // Every feature clamps to zero and biases 3 and 7 tie
        for (int i = 0; i < NCH*KSIZE*KSIZE; i++) conv_w_m[i] = 0;
        for (int i = 0; i < NCH; i++) conv_b_m[i] = -128;
        for (int i = 0; i < NCLASS; i++) fc_b_m[i] = rand_byte() >>> 1;
        fc_b_m[3] = 100;
        fc_b_m[7] = 100;
        load_conv();
        load_fc_b();
        new_image();
        run_frame(0, "zero features");
        check_equal(last_result, 3, "tie goes to the lowest index");

        new_coefs();
        load_conv();
        load_fc_w();
        load_fc_b();
        new_image();
        for (int i = 0; i < 70; i++) begin
            @(posedge clk_i);
            pix_i <= '{valid: 1'b1, data: pix_t'(img_m[i / IMG_SIZE][i % IMG_SIZE])};
        end
        apply_reset();
        @(posedge clk_i);
        check_equal(int'(done_o), 0, "done_o after reset");
        check_equal(int'(result_o), 0, "result_o after reset");

        // Only biases written, so the cleared weights leave bias 9 winning
        for (int i = 0; i < NCH*KSIZE*KSIZE; i++) conv_w_m[i] = 0;
        for (int i = 0; i < NCH; i++) conv_b_m[i] = 0;
        for (int i = 0; i < NCLASS*NFEAT; i++) fc_w_m[i] = 0;
        for (int i = 0; i < NCLASS; i++) fc_b_m[i] = rand_byte() >>> 1;
        fc_b_m[9] = 127;
        load_fc_b();
        run_frame(0, "coefficients cleared by reset");
        check_equal(last_result, 9, "bias only after reset");

        new_coefs();
        load_conv();
        load_fc_w();
        load_fc_b();
        new_image();
        run_frame(0, "reload after reset");

        finish_run();
    end

endmodule

//--- logic/cnn_pkg.sv
package cnn_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Number formats

    typedef logic signed [7:0]  pix_t;          // INT8 image pixel
    typedef logic signed [7:0]  coef_t;         // Weight or bias
    typedef logic signed [19:0] acc_t;          // 25 products plus bias
    typedef logic signed [11:0] feat_t;
    typedef logic signed [25:0] fc_acc_t;       // 48 features times weight

    localparam int KSIZE      = 5;
    localparam int NCH        = 3;
    localparam int NCLASS     = 10;
    localparam int CONV_SHIFT = 7;              // Rescale after bias add

    ////////////////////////////////////////////////////////////////////////
    // Encodings and bundles

    typedef enum logic [1:0] {
        CONV_W,
        CONV_B,
        FC_W,
        FC_B
    } coef_kind_e;

    typedef enum logic [1:0] {
        FC_IDLE,
        FC_ACCUM,
        FC_SCAN
    } fc_state_e;

    typedef struct packed {
        logic valid;
        pix_t data;
    } pix_strobe_t;

    typedef struct packed {
        logic       valid;
        coef_kind_e kind;
        logic [9:0] addr;
        coef_t      data;
    } coef_wr_t;

    typedef struct packed {
        logic                   valid;
        pix_t [KSIZE*KSIZE-1:0] pix;            // Index r*KSIZE + c
    } window_t;

    typedef struct packed {
        logic            valid;
        feat_t [NCH-1:0] feat;
    } conv_vec_t;

endpackage

//--- logic/cnn_top.sv
`timescale 1ns/10ps

module cnn_top #(
    parameter int IMG_SIZE = 12                 // Image side, even
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  cnn_pkg::pix_strobe_t pix_i,
    input  cnn_pkg::coef_wr_t    coef_i,
    output logic [3:0]           result_o,
    output logic                 done_o
);
    import cnn_pkg::*;

    localparam int POOL_SIZE = (IMG_SIZE - (KSIZE - 1)) / 2;
    localparam int NFEAT     = NCH * POOL_SIZE * POOL_SIZE;

    coef_t [NCH*KSIZE*KSIZE-1:0] conv_w;
    coef_t [NCH-1:0]             conv_b;
    coef_t [NCLASS*NFEAT-1:0]    fc_w;
    coef_t [NCLASS-1:0]          fc_b;

    window_t   win;
    conv_vec_t conv_vec;                        // Raw convolution outputs
    conv_vec_t pool_vec;                        // Pooled features

    coef_store #(.IMG_SIZE(IMG_SIZE)) coef_store_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .coef_i   (coef_i),
        .conv_w_o (conv_w),
        .conv_b_o (conv_b),
        .fc_w_o   (fc_w),
        .fc_b_o   (fc_b)
    );

    line_window #(.IMG_SIZE(IMG_SIZE)) line_window_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .pix_i  (pix_i),
        .win_o  (win)
    );

    conv_pe conv_pe_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .win_i    (win),
        .conv_w_i (conv_w),
        .conv_b_i (conv_b),
        .conv_o   (conv_vec)
    );

    pool_relu #(.IMG_SIZE(IMG_SIZE)) pool_relu_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .conv_i (conv_vec),
        .pool_o (pool_vec)
    );

    fc_argmax #(.IMG_SIZE(IMG_SIZE)) fc_argmax_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .pool_i   (pool_vec),
        .fc_w_i   (fc_w),
        .fc_b_i   (fc_b),
        .result_o (result_o),
        .done_o   (done_o)
    );

endmodule

//--- logic/coef_store.sv
`timescale 1ns/10ps

module coef_store #(
    parameter  int IMG_SIZE  = 12,
    localparam int POOL_SIZE = (IMG_SIZE - (cnn_pkg::KSIZE - 1)) / 2,
    localparam int NFEAT     = cnn_pkg::NCH * POOL_SIZE * POOL_SIZE
) (
    input  logic                                                         clk_i,
    input  logic                                                         rstn_i,
    input  cnn_pkg::coef_wr_t                                            coef_i,
    output cnn_pkg::coef_t [cnn_pkg::NCH*cnn_pkg::KSIZE*cnn_pkg::KSIZE-1:0] conv_w_o,
    output cnn_pkg::coef_t [cnn_pkg::NCH-1:0]                            conv_b_o,
    output cnn_pkg::coef_t [cnn_pkg::NCLASS*NFEAT-1:0]                   fc_w_o,
    output cnn_pkg::coef_t [cnn_pkg::NCLASS-1:0]                         fc_b_o
);
    import cnn_pkg::*;

    localparam int NCONV_W = NCH * KSIZE * KSIZE;
    localparam int NFC_W   = NCLASS * NFEAT;

    coef_t [NCONV_W-1:0] conv_w_q;
    coef_t [NCH-1:0]     conv_b_q;
    coef_t [NFC_W-1:0]   fc_w_q;
    coef_t [NCLASS-1:0]  fc_b_q;

    // Number of entries behind each kind
    function automatic int addr_limit(coef_kind_e kind);
        case (kind)
            CONV_W:  return NCONV_W;
            CONV_B:  return NCH;
            FC_W:    return NFC_W;
            default: return NCLASS;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            conv_w_q <= '0;
            conv_b_q <= '0;
            fc_w_q   <= '0;
            fc_b_q   <= '0;
        end else if (coef_i.valid) begin
            for (int i = 0; i < NCONV_W; i++) begin
                if (coef_i.kind == CONV_W && coef_i.addr == 10'(i)) conv_w_q[i] <= coef_i.data;
            end
            for (int i = 0; i < NCH; i++) begin
                if (coef_i.kind == CONV_B && coef_i.addr == 10'(i)) conv_b_q[i] <= coef_i.data;
            end
            for (int i = 0; i < NFC_W; i++) begin
                if (coef_i.kind == FC_W && coef_i.addr == 10'(i)) fc_w_q[i] <= coef_i.data;
            end
            for (int i = 0; i < NCLASS; i++) begin
                if (coef_i.kind == FC_B && coef_i.addr == 10'(i)) fc_b_q[i] <= coef_i.data;
            end
        end
    end

    assign conv_w_o = conv_w_q;
    assign conv_b_o = conv_b_q;
    assign fc_w_o   = fc_w_q;
    assign fc_b_o   = fc_b_q;

    // Out of range writes would silently drop a coefficient
    addr_range_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        coef_i.valid |-> int'(coef_i.addr) < addr_limit(coef_i.kind))
        else $error("coefficient address %0d out of range", coef_i.addr);

endmodule

//--- logic/conv_pe.sv
`timescale 1ns/10ps

module conv_pe (
    input  logic                                                         clk_i,
    input  logic                                                         rstn_i,
    input  cnn_pkg::window_t                                             win_i,
    input  cnn_pkg::coef_t [cnn_pkg::NCH*cnn_pkg::KSIZE*cnn_pkg::KSIZE-1:0] conv_w_i,
    input  cnn_pkg::coef_t [cnn_pkg::NCH-1:0]                            conv_b_i,
    output cnn_pkg::conv_vec_t                                           conv_o
);
    import cnn_pkg::*;

    localparam int   NTAP     = KSIZE * KSIZE;
    localparam acc_t FEAT_MAX = acc_t'(2 ** ($bits(feat_t) - 1) - 1);
    localparam acc_t FEAT_MIN = -FEAT_MAX - acc_t'(1);

    logic signed [15:0] prod_q [NCH][NTAP];     // Stage one products
    logic               valid1_q;
    logic               valid2_q;
    acc_t               sum    [NCH];
    acc_t               scaled [NCH];
    feat_t [NCH-1:0]    feat;
    feat_t [NCH-1:0]    feat_q;

    always_ff @(posedge clk_i) begin
        for (int ch = 0; ch < NCH; ch++) begin
            for (int k = 0; k < NTAP; k++) begin
                prod_q[ch][k] <= $signed(win_i.pix[k]) * $signed(conv_w_i[ch*NTAP + k]);
            end
        end
    end

    // Adder tree, scale and clamp
    always_comb begin
        for (int ch = 0; ch < NCH; ch++) begin
            sum[ch] = acc_t'(conv_b_i[ch]);
            for (int k = 0; k < NTAP; k++) begin
                sum[ch] = sum[ch] + acc_t'(prod_q[ch][k]);
            end
            scaled[ch] = sum[ch] >>> CONV_SHIFT;
            if (scaled[ch] > FEAT_MAX) begin
                feat[ch] = feat_t'(FEAT_MAX);
            end else if (scaled[ch] < FEAT_MIN) begin
                feat[ch] = feat_t'(FEAT_MIN);
            end else begin
                feat[ch] = feat_t'(scaled[ch]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        feat_q <= feat;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else begin
            valid1_q <= win_i.valid;
            valid2_q <= valid1_q;
        end
    end

    assign conv_o = '{valid: valid2_q, feat: feat_q};

endmodule

//--- logic/fc_argmax.sv
`timescale 1ns/10ps

module fc_argmax #(
    parameter  int IMG_SIZE  = 12,
    localparam int POOL_SIZE = (IMG_SIZE - (cnn_pkg::KSIZE - 1)) / 2,
    localparam int NFEAT     = cnn_pkg::NCH * POOL_SIZE * POOL_SIZE
) (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  cnn_pkg::conv_vec_t                         pool_i,
    input  cnn_pkg::coef_t [cnn_pkg::NCLASS*NFEAT-1:0] fc_w_i,
    input  cnn_pkg::coef_t [cnn_pkg::NCLASS-1:0]       fc_b_i,
    output logic [3:0]                                 result_o,
    output logic                                       done_o
);
    import cnn_pkg::*;

    localparam int NVEC = POOL_SIZE * POOL_SIZE;  // Pooled vectors per image
    localparam int VW   = $clog2(NVEC + 1);

    fc_state_e     state_q;
    logic [VW-1:0] vec_q;
    logic [3:0]    scan_q;
    logic [3:0]    best_q;
    fc_acc_t       max_q;
    fc_acc_t       acc_q   [NCLASS];
    fc_acc_t       acc_nxt [NCLASS];
    logic          last_vec;
    logic          take;                        // Scanned neuron beats the running max

    assign last_vec = (vec_q == VW'(NVEC - 1));
    assign take     = (scan_q == 4'd0) || (acc_q[scan_q] > max_q);

    always_comb begin
        for (int n = 0; n < NCLASS; n++) begin
            acc_nxt[n] = acc_q[n];
            for (int ch = 0; ch < NCH; ch++) begin
                acc_nxt[n] = acc_nxt[n] + $signed(pool_i.feat[ch])
                           * $signed(fc_w_i[n*NFEAT + int'(vec_q)*NCH + ch]);
            end
            if (last_vec) begin
                acc_nxt[n] = acc_nxt[n] + fc_acc_t'(fc_b_i[n]);  // Bias with final vector
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q  <= FC_IDLE;
            vec_q    <= '0;
            scan_q   <= '0;
            best_q   <= '0;
            max_q    <= '0;
            result_o <= '0;
            done_o   <= 1'b0;
            for (int n = 0; n < NCLASS; n++) begin
                acc_q[n] <= '0;
            end
        end else begin
            done_o <= 1'b0;
            case (state_q)
                FC_IDLE, FC_ACCUM: begin
                    if (pool_i.valid) begin
                        acc_q <= acc_nxt;
                        if (last_vec) begin
                            state_q <= FC_SCAN;
                            vec_q   <= '0;
                            scan_q  <= '0;
                        end else begin
                            state_q <= FC_ACCUM;
                            vec_q   <= vec_q + 1'b1;
                        end
                    end
                end
                FC_SCAN: begin
                    if (take) begin
                        max_q  <= acc_q[scan_q];
                        best_q <= scan_q;
                    end
                    if (scan_q == 4'(NCLASS - 1)) begin
                        state_q  <= FC_IDLE;
                        done_o   <= 1'b1;
                        result_o <= take ? scan_q : best_q;
                        for (int n = 0; n < NCLASS; n++) begin
                            acc_q[n] <= '0;     // Ready for the next image
                        end
                    end else begin
                        scan_q <= scan_q + 1'b1;
                    end
                end
                default: state_q <= FC_IDLE;
            endcase
        end
    end

    // Upstream must not start a new image before done
    no_feat_in_scan_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_q == FC_SCAN |-> !pool_i.valid);

endmodule

//--- logic/line_window.sv
`timescale 1ns/10ps

module line_window #(
    parameter int IMG_SIZE = 12
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  cnn_pkg::pix_strobe_t pix_i,
    output cnn_pkg::window_t     win_o
);
    import cnn_pkg::*;

    localparam int CW    = $clog2(IMG_SIZE);
    localparam int NLINE = KSIZE - 1;

    logic [CW-1:0] row_q;
    logic [CW-1:0] col_q;
    logic          valid_q;
    logic          last_col;
    logic          last_row;
    logic          fits;                        // Full kernel ends at this pixel

    pix_t                        lbuf_q [NLINE][IMG_SIZE];  // Line 0 is the row above
    pix_t [KSIZE-1:0][KSIZE-1:0] win_q;         // Indexed [r][c] with r 0 the oldest row
    pix_t [KSIZE-1:0]            col_vec;       // New window column, top to bottom

    assign last_col = (col_q == CW'(IMG_SIZE - 1));
    assign last_row = (row_q == CW'(IMG_SIZE - 1));
    assign fits     = (row_q >= CW'(NLINE)) && (col_q >= CW'(NLINE));

    always_comb begin
        col_vec[KSIZE-1] = pix_i.data;
        for (int r = 0; r < NLINE; r++) begin
            col_vec[r] = lbuf_q[NLINE-1-r][col_q];
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Position counters

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            row_q   <= '0;
            col_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= pix_i.valid && fits;
            if (pix_i.valid) begin
                col_q <= last_col ? '0 : col_q + 1'b1;
                if (last_col) begin
                    row_q <= last_row ? '0 : row_q + 1'b1;  // Wrap after last pixel
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Line buffers and window shift

    always_ff @(posedge clk_i) begin
        if (pix_i.valid) begin
            lbuf_q[0][col_q] <= pix_i.data;
            for (int k = 1; k < NLINE; k++) begin
                lbuf_q[k][col_q] <= lbuf_q[k-1][col_q];    // Push column down a line
            end
            for (int r = 0; r < KSIZE; r++) begin
                win_q[r] <= {col_vec[r], win_q[r][KSIZE-1:1]};
            end
        end
    end

    assign win_o = '{valid: valid_q, pix: win_q};

endmodule

//--- logic/pool_relu.sv
`timescale 1ns/10ps

module pool_relu #(
    parameter int IMG_SIZE = 12
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  cnn_pkg::conv_vec_t conv_i,
    output cnn_pkg::conv_vec_t pool_o
);
    import cnn_pkg::*;

    localparam int CONV_SIZE = IMG_SIZE - (KSIZE - 1);
    localparam int POOL_SIZE = CONV_SIZE / 2;
    localparam int CW        = $clog2(CONV_SIZE);

    logic [CW-1:0]   row_q;
    logic [CW-1:0]   col_q;
    logic [CW-2:0]   pcol;                      // Pooled column
    logic            last_col;
    logic            last_row;
    logic            valid_q;
    feat_t [NCH-1:0] left_q;                    // Even column of the pair
    feat_t [NCH-1:0] hbuf_q [POOL_SIZE];        // Pair maxima of the even row
    feat_t [NCH-1:0] pair_max;
    feat_t [NCH-1:0] blk_max;
    feat_t [NCH-1:0] pool_q;

    assign pcol     = col_q[CW-1:1];
    assign last_col = (col_q == CW'(CONV_SIZE - 1));
    assign last_row = (row_q == CW'(CONV_SIZE - 1));

    always_comb begin
        for (int ch = 0; ch < NCH; ch++) begin
            pair_max[ch] = (conv_i.feat[ch] > left_q[ch]) ? conv_i.feat[ch] : left_q[ch];
            blk_max[ch]  = (hbuf_q[pcol][ch] > pair_max[ch]) ? hbuf_q[pcol][ch] : pair_max[ch];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            row_q   <= '0;
            col_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= conv_i.valid && row_q[0] && col_q[0];
            if (conv_i.valid) begin
                col_q <= last_col ? '0 : col_q + 1'b1;
                if (last_col) begin
                    row_q <= last_row ? '0 : row_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (conv_i.valid) begin
            if (!col_q[0]) begin
                left_q <= conv_i.feat;
            end else if (!row_q[0]) begin
                hbuf_q[pcol] <= pair_max;
            end else begin
                for (int ch = 0; ch < NCH; ch++) begin
                    pool_q[ch] <= blk_max[ch][$bits(feat_t)-1] ? '0 : blk_max[ch];  // ReLU
                end
            end
        end
    end

    assign pool_o = '{valid: valid_q, feat: pool_q};

endmodule

//--- vlog.f
+incdir+bench
logic/cnn_pkg.sv
logic/coef_store.sv
logic/line_window.sv
logic/conv_pe.sv
logic/pool_relu.sv
logic/fc_argmax.sv
logic/cnn_top.sv
bench/cnn_tb.sv
